//--- hw/imager_params.svh
`ifndef IMAGER_PARAMS_SVH
`define IMAGER_PARAMS_SVH

// data widths
`define PIX_W        8    // one sensor byte
`define WORD_W       24   // three bytes per frame word
`define PAT_W        10   // mask pattern
`define WB_DW        32
`define WB_AW        3    // word address

// fifo sizing
`define FRAME_DEPTH  16
`define FRAME_AFULL  12   // almost-full level
`define PAT_DEPTH    8

// register map, word addresses
`define REG_CTRL     3'd0
`define REG_EXP      3'd1
`define REG_NPAT     3'd2
`define REG_PAT      3'd3
`define REG_PIX      3'd4
`define REG_STAT     3'd5

`endif

//--- hw/imager_pkg.sv
`default_nettype none

`include "imager_params.svh"

package imager_pkg;

	////////////////////////////////////////
	// wishbone classic bus

	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [`WB_AW-1:0]   adr;   // word address
		logic [`WB_DW-1:0]   dat_w;
	} wb_req_t;

	typedef struct packed {
		logic                ack;   // single cycle
		logic [`WB_DW-1:0]   dat_r;
	} wb_rsp_t;

	////////////////////////////////////////
	// payloads and sequencer

	typedef logic [`WORD_W-1:0] pix_word_t;  // b2,b1,b0 with b0 low
	typedef logic [`PAT_W-1:0]  pattern_t;

	typedef struct packed {
		logic [15:0] exp_cycles;  // cycles per subframe
		logic [15:0] num_pat;     // subframes per run
	} exp_cfg_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_PIXRES,
		SEQ_EXPOSE,
		SEQ_DONE
	} seq_state_t;

endpackage

`default_nettype wire

//--- hw/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "imager_params.svh"

module sync_fifo import imager_pkg::*; #(
	parameter type T     = pix_word_t,
	parameter int  DEPTH = `FRAME_DEPTH,
	parameter int  AFULL = `FRAME_AFULL
) (
	input  wire logic CLK_HS,
	input  wire logic rst,
	input  wire logic push,
	input  wire T     din,
	input  wire logic pop,
	output T          dout,
	output logic      empty,
	output logic      full,
	output logic      afull
);

	localparam int AW = $clog2(DEPTH);

	T              mem [DEPTH];  // storage, no reset
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   level;        // 0..DEPTH
	logic          do_push;
	logic          do_pop;

	assign do_push = push && !full;   // drop on full
	assign do_pop  = pop && !empty;   // nothing to pop

	always_ff @(posedge CLK_HS) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;  // both or neither
			endcase
		end
	end

	always_ff @(posedge CLK_HS) begin
		if (do_push) begin
			mem[wr_ptr] <= din;
		end
	end

	// first word falls through
	assign dout  = mem[rd_ptr];
	assign empty = (level == '0);
	assign full  = (level == (AW+1)'(DEPTH));
	assign afull = (level >= (AW+1)'(AFULL));

	a_level_max: assert property (@(posedge CLK_HS) disable iff (rst)
		level <= (AW+1)'(DEPTH));

endmodule

`default_nettype wire

//--- hw/pixel_packer.sv
`timescale 1ns/1ps
`default_nettype none

`include "imager_params.svh"

module pixel_packer import imager_pkg::*; (
	input  wire logic             CLK_HS,
	input  wire logic             rst,
	input  wire logic [`PIX_W-1:0] im_data,
	input  wire logic             im_data_val,
	output pix_word_t             word,
	output logic                  word_val
);

	logic [1:0] byte_cnt;  // modulo three
	pix_word_t  sr;

	always_ff @(posedge CLK_HS) begin
		if (rst) begin
			byte_cnt <= 2'd0;
			word_val <= 1'b0;
		end else begin
			word_val <= im_data_val && (byte_cnt == 2'd2);  // third byte seen
			if (im_data_val) begin
				byte_cnt <= (byte_cnt == 2'd2) ? 2'd0 : byte_cnt + 2'd1;
			end
		end
	end

	// new byte enters at the top, first byte ends up in bits 7:0
	always_ff @(posedge CLK_HS) begin
		if (im_data_val) begin
			sr <= {im_data, sr[`WORD_W-1:`PIX_W]};
		end
	end

	assign word = sr;  // only meaningful with word_val

endmodule

`default_nettype wire

//--- hw/exposure_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "imager_params.svh"

module exposure_seq import imager_pkg::*; (
	input  wire logic     CLK_HS,
	input  wire logic     rst,
	input  wire logic     start,
	input  wire exp_cfg_t cfg,
	output seq_state_t    state,
	output logic          pixres,
	output logic          stream
);

	exp_cfg_t    cfg_q;     // latched at start
	logic [15:0] cyc_cnt;   // 1..exp_cycles
	logic [15:0] sub_cnt;   // 1..num_pat
	logic        go;

	// zero length or zero count runs are refused
	assign go = start && (cfg.exp_cycles != 16'd0) && (cfg.num_pat != 16'd0);

	assign pixres = (state == SEQ_PIXRES);
	assign stream = (state == SEQ_EXPOSE) && (cyc_cnt == cfg_q.exp_cycles);  // last cycle

	////////////////////////////////////////
	// sequencer FSM

	always_ff @(posedge CLK_HS) begin
		if (rst) begin
			state   <= SEQ_IDLE;
			cyc_cnt <= 16'd0;
			sub_cnt <= 16'd0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (go) begin
						state <= SEQ_PIXRES;
					end
				end
				SEQ_PIXRES: begin  // one cycle global reset
					state   <= SEQ_EXPOSE;
					cyc_cnt <= 16'd1;
					sub_cnt <= 16'd1;
				end
				SEQ_EXPOSE: begin
					if (stream) begin
						if (sub_cnt == cfg_q.num_pat) begin
							state <= SEQ_DONE;  // last subframe
						end else begin
							sub_cnt <= sub_cnt + 16'd1;
							cyc_cnt <= 16'd1;
						end
					end else begin
						cyc_cnt <= cyc_cnt + 16'd1;
					end
				end
				default: state <= SEQ_IDLE;  // done lasts one cycle
			endcase
		end
	end

	always_ff @(posedge CLK_HS) begin
		if ((state == SEQ_IDLE) && go) begin
			cfg_q <= cfg;
		end
	end

	a_stream_in_expose: assert property (@(posedge CLK_HS) disable iff (rst)
		(state != SEQ_EXPOSE) |-> !stream);

endmodule

`default_nettype wire

//--- hw/host_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "imager_params.svh"

module host_regs import imager_pkg::*; (
	input  wire logic       CLK_HS,
	input  wire logic       rst,
	input  wire wb_req_t    wb_req,
	output wb_rsp_t         wb_rsp,
	input  wire pix_word_t  frame_head,
	input  wire logic       frame_empty,
	input  wire logic       frame_full,
	input  wire logic       frame_afull,
	input  wire logic       overflow,
	input  wire logic       pat_empty,
	input  wire logic       pat_full,
	input  wire seq_state_t state,
	output logic            soft_rst,
	output logic            start,
	output exp_cfg_t        cfg,
	output logic            pat_push,
	output pattern_t        pat_data,
	output logic            frame_pop
);

	logic              ack_q;
	logic [`WB_DW-1:0] dat_r_q;
	logic [`WB_DW-1:0] rd_mux;
	logic              req;
	logic              wr;
	logic              rd;

	////////////////////////////////////////
	// bus decode

	// ack_q masks the second cycle of a held request
	assign req = wb_req.cyc && wb_req.stb && !ack_q;
	assign wr  = req && wb_req.we;
	assign rd  = req && !wb_req.we;

	// strobes land on the edge that raises ack
	assign frame_pop = rd && (wb_req.adr == `REG_PIX) && !frame_empty;  // empty read pops nothing
	assign pat_push  = wr && (wb_req.adr == `REG_PAT) && !pat_full && (state == SEQ_IDLE);
	assign pat_data  = wb_req.dat_w[`PAT_W-1:0];

	always_comb begin
		rd_mux = '0;
		case (wb_req.adr)
			`REG_CTRL: rd_mux = {{(`WB_DW-1){1'b0}}, soft_rst};
			`REG_EXP:  rd_mux = {16'h0, cfg.exp_cycles};
			`REG_NPAT: rd_mux = {16'h0, cfg.num_pat};
			`REG_PIX: begin
				if (!frame_empty) begin
					rd_mux = {{(`WB_DW-`WORD_W){1'b0}}, frame_head};  // fwft head
				end
			end
			`REG_STAT: rd_mux = {22'h0, state, 3'b000, pat_empty, overflow,
				frame_empty, frame_full, frame_afull};
			default: rd_mux = '0;  // unmapped and write-only
		endcase
	end

	////////////////////////////////////////
	// registers

	always_ff @(posedge CLK_HS) begin
		if (rst) begin
			ack_q    <= 1'b0;
			start    <= 1'b0;
			soft_rst <= 1'b0;
			cfg      <= '0;
		end else begin
			ack_q <= req;
			start <= wr && (wb_req.adr == `REG_CTRL) && wb_req.dat_w[1];  // one cycle
			if (wr) begin
				case (wb_req.adr)
					`REG_CTRL: soft_rst <= wb_req.dat_w[0];  // level, held
					`REG_EXP:  cfg.exp_cycles <= wb_req.dat_w[15:0];
					`REG_NPAT: cfg.num_pat <= wb_req.dat_w[15:0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge CLK_HS) begin
		if (req) begin
			dat_r_q <= rd_mux;  // valid with ack
		end
	end

	assign wb_rsp.ack   = ack_q;
	assign wb_rsp.dat_r = dat_r_q;

	// held requests still get single-cycle acks
	a_ack_single: assert property (@(posedge CLK_HS) disable iff (rst)
		wb_rsp.ack |=> !wb_rsp.ack);

endmodule

`default_nettype wire

//--- hw/imager_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "imager_params.svh"

module imager_top import imager_pkg::*; (
	input  wire logic              CLK_HS,
	input  wire logic              rst,
	input  wire wb_req_t           wb_req,
	input  wire logic [`PIX_W-1:0] im_data,
	input  wire logic              im_data_val,
	output wb_rsp_t                wb_rsp,
	output logic                   stream,
	output pattern_t               mstream,
	output logic                   pixres,
	output logic [5:0]             led
);

	logic       soft_rst;
	logic       blk_rst;     // hard or soft
	logic       start;
	exp_cfg_t   cfg;
	seq_state_t state;
	logic       pat_push;
	pattern_t   pat_data;
	pattern_t   pat_head;
	logic       pat_empty;
	logic       pat_full;
	logic       frame_pop;
	pix_word_t  frame_head;
	logic       frame_empty;
	logic       frame_full;
	logic       frame_afull;
	pix_word_t  word;
	logic       word_val;
	logic       overflow;

	assign blk_rst = rst || soft_rst;

	host_regs u_regs (
		.CLK_HS(CLK_HS), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp),
		.frame_head(frame_head), .frame_empty(frame_empty), .frame_full(frame_full),
		.frame_afull(frame_afull), .overflow(overflow), .pat_empty(pat_empty),
		.pat_full(pat_full), .state(state), .soft_rst(soft_rst), .start(start),
		.cfg(cfg), .pat_push(pat_push), .pat_data(pat_data), .frame_pop(frame_pop)
	);

	////////////////////////////////////////
	// pixel path

	pixel_packer u_packer (
		.CLK_HS(CLK_HS), .rst(blk_rst), .im_data(im_data), .im_data_val(im_data_val),
		.word(word), .word_val(word_val)
	);

	sync_fifo #(.T(pix_word_t), .DEPTH(`FRAME_DEPTH), .AFULL(`FRAME_AFULL)) frame_fifo (
		.CLK_HS(CLK_HS), .rst(blk_rst), .push(word_val), .din(word), .pop(frame_pop),
		.dout(frame_head), .empty(frame_empty), .full(frame_full), .afull(frame_afull)
	);

	// sticky, word lost on a full fifo
	always_ff @(posedge CLK_HS) begin
		if (blk_rst) begin
			overflow <= 1'b0;
		end else if (word_val && frame_full) begin
			overflow <= 1'b1;
		end
	end

	////////////////////////////////////////
	// pattern path and sequencer

	sync_fifo #(.T(pattern_t), .DEPTH(`PAT_DEPTH), .AFULL(`PAT_DEPTH)) pat_fifo (
		.CLK_HS(CLK_HS), .rst(blk_rst), .push(pat_push), .din(pat_data), .pop(stream),
		.dout(pat_head), .empty(pat_empty), .full(pat_full), .afull()
	);

	exposure_seq u_seq (
		.CLK_HS(CLK_HS), .rst(blk_rst), .start(start), .cfg(cfg),
		.state(state), .pixres(pixres), .stream(stream)
	);

	assign mstream = pat_empty ? '0 : pat_head;  // no stale head
	assign led     = {state, pat_empty, frame_afull, frame_full, overflow};

endmodule

`default_nettype wire

//--- verif/imager_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "imager_params.svh"

module imager_tb import imager_pkg::*; ();

	// bytes at up to 4 cycles plus bus transfers at 3 plus run and guard waits
	localparam int TEST_CYCLES    = 90 * 4 + 80 * 3 + 2 * 40 + 60;
	localparam int TIMEOUT_CYCLES = 7 * TEST_CYCLES;  // ~5000

	logic              CLK_HS = 1'b0;
	logic              rst;
	wb_req_t           wb_req;
	wb_rsp_t           wb_rsp;
	logic [`PIX_W-1:0] im_data;
	logic              im_data_val;
	logic              stream;
	pattern_t          mstream;
	logic              pixres;
	logic [5:0]        led;

	logic [15:0]       lfsr_q = 16'd35;  // seed
	logic [7:0]        byte_buf [$];     // bytes of the word being gathered
	pix_word_t         frame_q [$];      // expected frame fifo contents
	logic              exp_ovf;
	pattern_t          pat_q [$];        // loaded patterns in stream order
	int                exp_gap;
	int                cycle_cnt = 0;
	int                last_evt = 0;
	int                n_pixres = 0;
	int                n_stream = 0;
	int                n_checks = 0;
	int                n_errors = 0;

	imager_top dut0 (
		.CLK_HS(CLK_HS), .rst(rst), .wb_req(wb_req), .im_data(im_data),
		.im_data_val(im_data_val), .wb_rsp(wb_rsp), .stream(stream),
		.mstream(mstream), .pixres(pixres), .led(led)
	);

	always #5 CLK_HS = ~CLK_HS;  // 100 MHz

	// hard stop if anything hangs
	always @(posedge CLK_HS) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the tests did not complete", cycle_cnt);
			$display("*** FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////
	// helpers

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // galois with taps x^16+x^14+x^13+x^11+1
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);  // one step per bit
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		n_checks++;
		if (exp !== act) begin
			$display("mismatch %s: expected %h actual %h", name, exp, act);
			n_errors++;
		end
	endtask

	// led looked at mid-cycle
	task automatic sample_led(input string name, input logic [5:0] exp);
		@(negedge CLK_HS);
		check(name, 32'(exp), 32'(led));
	endtask

	////////////////////////////////////////
	// reference model

	// first byte lands in the low bits
	function automatic pix_word_t pack_word(input logic [7:0] b0, b1, b2);
		return {b2, b1, b0};
	endfunction

	// status word from the modelled fifo level and flags
	function automatic logic [31:0] stat_expect(input int level, input logic ovf,
		input logic pat_empty, input logic [1:0] st);
		logic [31:0] s;
		s      = '0;
		s[0]   = (level >= `FRAME_AFULL);
		s[1]   = (level == `FRAME_DEPTH);
		s[2]   = (level == 0);
		s[3]   = ovf;
		s[4]   = pat_empty;
		s[9:8] = st;
		return s;
	endfunction

	// led bits from the same modelled state
	function automatic logic [5:0] led_expect(input int level, input logic ovf,
		input logic pat_empty, input logic [1:0] st);
		logic [5:0] l;
		l[5:4] = st;
		l[3]   = pat_empty;
		l[2]   = (level >= `FRAME_AFULL);
		l[1]   = (level == `FRAME_DEPTH);
		l[0]   = ovf;
		return l;
	endfunction

	task automatic model_byte(input logic [7:0] b);
		byte_buf.push_back(b);
		if (byte_buf.size() == 3) begin
			if (frame_q.size() < `FRAME_DEPTH) begin
				frame_q.push_back(pack_word(byte_buf[0], byte_buf[1], byte_buf[2]));
			end else begin
				exp_ovf = 1'b1;  // word lost
			end
			byte_buf.delete();
		end
	endtask

	////////////////////////////////////////
	// stimulus and bus

	task automatic send_bytes(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			take_bits(2, r);
			repeat (r[1:0]) begin  // 0..3 idle cycles
				@(posedge CLK_HS);
				im_data_val <= 1'b0;
			end
			take_bits(8, r);
			@(posedge CLK_HS);
			im_data     <= r[7:0];
			im_data_val <= 1'b1;
			model_byte(r[7:0]);
		end
		@(posedge CLK_HS);
		im_data_val <= 1'b0;
	endtask

	// classic cycle with the request held until ack
	task automatic wb_cycle(input logic we, input logic [`WB_AW-1:0] adr,
		input logic [31:0] dat, output logic [31:0] rdata);
		wb_req_t r;
		r.cyc   = 1'b1;
		r.stb   = 1'b1;
		r.we    = we;
		r.adr   = adr;
		r.dat_w = dat;
		@(posedge CLK_HS);
		wb_req <= r;
		do begin
			@(negedge CLK_HS);  // mid-cycle sample
		end while (!wb_rsp.ack);
		rdata = wb_rsp.dat_r;
		@(posedge CLK_HS);
		wb_req <= '0;
	endtask

	task automatic wb_write(input logic [`WB_AW-1:0] adr, input logic [31:0] dat);
		logic [31:0] unused_rd;
		wb_cycle(1'b1, adr, dat, unused_rd);
	endtask

	task automatic wb_read(input logic [`WB_AW-1:0] adr, output logic [31:0] dat);
		wb_cycle(1'b0, adr, '0, dat);
	endtask

	// compares every pulse against the loaded patterns
	always @(negedge CLK_HS) begin
		if (!rst) begin
			if (pixres) begin
				n_pixres++;
				last_evt = cycle_cnt;
			end
			if (stream) begin
				n_stream++;
				check("stream_gap", exp_gap, cycle_cnt - last_evt);
				check("led_state", 32'(SEQ_EXPOSE), 32'(led[5:4]));
				last_evt = cycle_cnt;
				if (pat_q.size() == 0) begin
					$display("stream pulse seen with no loaded pattern left to compare");
					n_errors++;
				end else begin
					check("mstream", 32'(pat_q.pop_front()), 32'(mstream));
				end
			end
		end
	end

	////////////////////////////////////////
	// test sequence

	initial begin
		logic [31:0] rd;
		logic [31:0] r;
		int          p0;
		int          s0;

		rst         = 1'b1;
		wb_req      = '0;
		im_data     = '0;
		im_data_val = 1'b0;
		exp_ovf     = 1'b0;
		exp_gap     = 7;
		repeat (3) @(posedge CLK_HS);
		rst <= 1'b0;

		// register readback
		wb_write(`REG_EXP, 32'h0000_1234);
		wb_write(`REG_NPAT, 32'h0000_0042);
		wb_read(`REG_EXP, rd);
		check("exp_readback", 32'h1234, rd);
		wb_read(`REG_NPAT, rd);
		check("npat_readback", 32'h0042, rd);
		wb_read(3'd6, rd);
		check("unmapped_6", 32'h0, rd);
		wb_read(3'd7, rd);
		check("unmapped_7", 32'h0, rd);

		// pixel packing of 30 bytes into 10 words
		send_bytes(30);
		for (int i = 0; i < 10; i++) begin
			wb_read(`REG_PIX, rd);
			check("pix_word", 32'(frame_q.pop_front()), rd);
		end
		wb_read(`REG_PIX, rd);
		check("pix_empty_read", 32'h0, rd);
		wb_read(`REG_STAT, rd);
		check("stat_after_pack", stat_expect(frame_q.size(), exp_ovf, 1'b1, 2'b00), rd);
		sample_led("led_after_pack", led_expect(frame_q.size(), exp_ovf, 1'b1, 2'b00));

		// flags and overflow with 20 words into 16 entries
		send_bytes(60);
		do begin
			wb_read(`REG_STAT, rd);
		end while (!rd[3]);  // wait for overflow
		check("stat_full", stat_expect(frame_q.size(), exp_ovf, 1'b1, 2'b00), rd);
		sample_led("led_full", led_expect(frame_q.size(), exp_ovf, 1'b1, 2'b00));
		for (int i = 0; i < `FRAME_DEPTH; i++) begin
			wb_read(`REG_PIX, rd);
			check("ovf_word", 32'(frame_q.pop_front()), rd);
		end
		wb_read(`REG_PIX, rd);
		check("ovf_extra_read", 32'h0, rd);
		wb_write(`REG_CTRL, 32'h1);  // soft reset on
		wb_write(`REG_CTRL, 32'h0);
		exp_ovf = 1'b0;
		wb_read(`REG_STAT, rd);
		check("stat_soft_rst", stat_expect(0, exp_ovf, 1'b1, 2'b00), rd);
		sample_led("led_soft_rst", led_expect(0, exp_ovf, 1'b1, 2'b00));

		// pattern streaming
		wb_write(`REG_EXP, 32'd7);
		wb_write(`REG_NPAT, 32'd5);
		exp_gap = 7;
		for (int i = 0; i < 5; i++) begin
			take_bits(`PAT_W, r);
			wb_write(`REG_PAT, r);
			pat_q.push_back(r[`PAT_W-1:0]);
		end
		@(negedge CLK_HS);
		check("mstream_head", 32'(pat_q[0]), 32'(mstream));
		sample_led("led_loaded", led_expect(0, 1'b0, 1'b0, 2'b00));
		p0 = n_pixres;
		s0 = n_stream;
		wb_write(`REG_CTRL, 32'h2);  // start
		wait (n_stream == s0 + 5);
		do begin
			wb_read(`REG_STAT, rd);
		end while (rd[9:8] != 2'b00);
		check("stat_run_idle", stat_expect(0, 1'b0, 1'b1, 2'b00), rd);
		check("pixres_count", 32'd1, n_pixres - p0);
		check("stream_count", 32'd5, n_stream - s0);
		check("patterns_left", 32'd0, pat_q.size());
		@(negedge CLK_HS);
		check("mstream_after", 32'h0, 32'(mstream));
		sample_led("led_run_idle", led_expect(0, 1'b0, 1'b1, 2'b00));

		// start guards with zero count then zero length
		for (int g = 0; g < 2; g++) begin
			wb_write(`REG_EXP, (g == 0) ? 32'd7 : 32'd0);
			wb_write(`REG_NPAT, (g == 0) ? 32'd0 : 32'd3);
			p0 = n_pixres;
			s0 = n_stream;
			wb_write(`REG_CTRL, 32'h2);
			repeat (20) @(posedge CLK_HS);  // longer than any short run
			check("guard_pixres", 32'(p0), n_pixres);
			check("guard_stream", 32'(s0), n_stream);
			wb_read(`REG_STAT, rd);
			check("guard_stat", stat_expect(0, 1'b0, 1'b1, 2'b00), rd);
		end

		repeat (2) @(posedge CLK_HS);
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hw
hw/imager_pkg.sv
hw/sync_fifo.sv
hw/pixel_packer.sv
hw/exposure_seq.sv
hw/host_regs.sv
hw/imager_top.sv
verif/imager_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the imager testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module imager_tb -Mdir obj_dir

out=$(./obj_dir/Vimager_tb)
echo "$out"
echo "$out" | grep -qF '*** PASSED ***'
